/* sources.f */
+incdir+verification
rtl/isa_pkg.sv
rtl/control_pkg.sv
rtl/operate_decoder.sv
rtl/memory_access_decoder.sv
rtl/flow_decoder.sv
rtl/trap_decoder.sv
rtl/execute_decoder.sv
rtl/instruction_sequencer.sv
rtl/lc3_control_unit.sv
verification/tb_lc3_control_unit.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = tb_lc3_control_unit
FILE_LIST = sources.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/control_model.svh */
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// expected control word and status for one cycle outside reset
function automatic void expected_control(
    input phase_t phase,
    input step_t step,
    input instruction_t ir,
    input condition_flags_t fl,
    input logic acc,
    output control_word_t cw,
    output step_status_t st
);
    opcode_t op;
    logic store;
    logic indirect;
    logic relative;
    cw = '0;
    st = '0;
    op = ir.operate.opcode;
    store = op inside {op_st, op_str, op_sti};
    indirect = op inside {op_ldi, op_sti};
    relative = op inside {op_ldr, op_str};
    if (phase == fetch_address) begin
        cw.buses.program_counter = 1'b1;
        cw.memory_read_enable = 1'b1;
    end else if (phase == fetch_load) begin
        cw.buses.memory_data = 1'b1;
        cw.loads.instruction_register = 1'b1;
        cw.loads.program_counter = 1'b1;
        cw.program_counter_mux_select = pc_increment;
    end else if (phase == execute) begin
        st.last_step = 1'b1; // most opcodes are one step
        case (op)
            op_add, op_and, op_not: begin
                cw.loads.register_file = 1'b1;
                cw.loads.flag_register = 1'b1;
                cw.buses.arithmetic_logic_unit = 1'b1;
                cw.register_file_in_address = ir.operate.dr;
                cw.register_file_out_a_address = ir.operate.sr1;
                if (op == op_not) begin
                    cw.arithmetic_logic_unit_select = alu_not;
                end else begin
                    cw.arithmetic_logic_unit_select = (op == op_and) ? alu_and : alu_add;
                    if (!ir.operate.imm_flag) begin
                        cw.register_file_out_b_address = ir.operate.sr2;
                        cw.arithmetic_logic_mux_select = 1'b1;
                    end
                end
            end
            op_lea: begin
                cw.loads.register_file = 1'b1;
                cw.loads.flag_register = 1'b1;
                cw.buses.memory_address = 1'b1;
                cw.memory_address_register_mux_select = 1'b1;
                cw.address_adder_mux_a_select = from_pc;
                cw.address_adder_mux_b_select = sext9;
                cw.register_file_in_address = ir.offset.dr_nzp;
            end
            op_ld, op_st, op_ldr, op_str, op_ldi, op_sti: begin
                st.last_step = (step == (indirect ? 2'd2 : 2'd1));
                if (step == (store ? 2'd1 : 2'd0)) begin // effective address step
                    cw.buses.memory_address = 1'b1;
                    cw.memory_address_register_mux_select = 1'b1;
                    cw.address_adder_mux_a_select = relative ? from_register : from_pc;
                    cw.address_adder_mux_b_select = relative ? sext6 : sext9;
                    cw.register_file_out_a_address = relative ? ir.base.base_r : 3'd0;
                    cw.memory_read_enable = !store || indirect;
                    cw.memory_write_enable = store && !indirect;
                end else if (store && step == 2'd0) begin
                    cw.buses.register_file_out_a = 1'b1;
                    cw.loads.memory_data_register = 1'b1;
                    cw.register_file_out_a_address = ir.base.dr_sr;
                end else if (st.last_step && store) begin // sti write through pointer
                    cw.buses.memory_data = 1'b1;
                    cw.memory_write_enable = 1'b1;
                end else if (st.last_step) begin
                    cw.buses.memory_data = 1'b1;
                    cw.loads.register_file = 1'b1;
                    cw.loads.flag_register = 1'b1;
                    cw.register_file_in_address = ir.base.dr_sr;
                end else begin // ldi pointer read
                    cw.buses.memory_data = 1'b1;
                    cw.memory_read_enable = 1'b1;
                end
            end
            op_br: begin
                cw.loads.program_counter = 1'b1;
                cw.buses.program_counter = 1'b1;
                cw.address_adder_mux_a_select = from_pc;
                cw.address_adder_mux_b_select = sext9;
                cw.program_counter_mux_select =
                    (ir.offset.dr_nzp == fl) ? pc_from_adder : pc_from_bus;
            end
            op_jmp: begin
                cw.loads.program_counter = 1'b1;
                cw.buses.register_file_out_a = 1'b1;
                cw.register_file_out_a_address = ir.base.base_r;
            end
            op_jsr: begin
                st.last_step = (step != 2'd0);
                if (step == 2'd0) begin
                    cw.loads.register_file = 1'b1;
                    cw.buses.program_counter = 1'b1;
                    cw.register_file_in_address = link_register;
                end else if (ir.jsr.long_flag) begin
                    cw.loads.program_counter = 1'b1;
                    cw.address_adder_mux_a_select = from_pc;
                    cw.address_adder_mux_b_select = sext11;
                    cw.program_counter_mux_select = pc_from_adder;
                end else begin
                    cw.loads.program_counter = 1'b1;
                    cw.buses.register_file_out_a = 1'b1;
                    cw.register_file_out_a_address = ir.base.base_r;
                end
            end
            op_trap: begin
                if (ir.trap.vector == trap_display) begin
                    cw.loads.seven_segment_display_register = 1'b1;
                    cw.buses.register_file_out_a = 1'b1;
                    cw.register_file_out_a_address = ir.trap.register;
                end else if (ir.trap.vector == trap_input) begin
                    st.last_step = acc;
                    cw.loads.register_file = acc;
                    cw.buses.switch_input = acc;
                    cw.register_file_in_address = acc ? ir.trap.register : 3'd0;
                end else begin
                    st.last_step = 1'b0;
                    st.halt_request = 1'b1;
                end
            end
            default: cw = '0; // rti and reserved
        endcase
    end
endfunction

`endif

/* verification/tb_lc3_control_unit.sv */
`timescale 1ns/1ps

module tb_lc3_control_unit;
    import isa_pkg::*;
    import control_pkg::*;

    localparam int instruction_count = 400;
    localparam int longest_instruction_cycles = 5; // two fetch cycles and three steps
    localparam int wait_allowance_cycles = 20; // input waits and halt resets
    localparam int timeout_cycles = instruction_count *
        (longest_instruction_cycles + wait_allowance_cycles);

    logic clock;
    logic reset;
    condition_flags_t flags;
    instruction_t instruction_register;
    logic accept;
    control_word_t control;

    integer seed;
    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    int instructions_done = 0;
    int reset_left;
    int halt_wait;
    logic load_pending;
    phase_t model_phase;
    step_t model_step;
    control_word_t expected;
    step_status_t expected_status;

    `include "control_model.svh"

    lc3_control_unit i_lc3_control_unit (
        .clock(clock),
        .reset(reset),
        .flags(flags),
        .instruction_register(instruction_register),
        .accept(accept),
        .control(control)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("checks %0d, errors %0d", check_count, error_count);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
            input logic [31:0] wanted);
        check_count++;
        if (actual !== wanted) begin
            error_count++;
            $display("Mismatch %s at %0t: got %h expected %h", name, $time, actual, wanted);
        end
    endtask

    task automatic check_control(input control_word_t actual, input control_word_t wanted);
        check_value("loads", 32'(actual.loads), 32'(wanted.loads));
        check_value("buses", 32'(actual.buses), 32'(wanted.buses));
        check_value("register_file_in_address", 32'(actual.register_file_in_address),
            32'(wanted.register_file_in_address));
        check_value("register_file_out_a_address", 32'(actual.register_file_out_a_address),
            32'(wanted.register_file_out_a_address));
        check_value("register_file_out_b_address", 32'(actual.register_file_out_b_address),
            32'(wanted.register_file_out_b_address));
        check_value("memory_address_register_mux_select",
            32'(actual.memory_address_register_mux_select),
            32'(wanted.memory_address_register_mux_select));
        check_value("program_counter_mux_select", 32'(actual.program_counter_mux_select),
            32'(wanted.program_counter_mux_select));
        check_value("address_adder_mux_a_select", 32'(actual.address_adder_mux_a_select),
            32'(wanted.address_adder_mux_a_select));
        check_value("address_adder_mux_b_select", 32'(actual.address_adder_mux_b_select),
            32'(wanted.address_adder_mux_b_select));
        check_value("arithmetic_logic_mux_select", 32'(actual.arithmetic_logic_mux_select),
            32'(wanted.arithmetic_logic_mux_select));
        check_value("arithmetic_logic_unit_select", 32'(actual.arithmetic_logic_unit_select),
            32'(wanted.arithmetic_logic_unit_select));
        check_value("memory_read_enable", 32'(actual.memory_read_enable),
            32'(wanted.memory_read_enable));
        check_value("memory_write_enable", 32'(actual.memory_write_enable),
            32'(wanted.memory_write_enable));
    endtask

    function automatic instruction_t random_instruction();
        instruction_t word;
        word = instruction_t'(16'($random(seed)));
        if (word.trap.opcode == op_trap) begin
            word.trap.vector = 8'($random(seed) & 32'd3); // 0 and 3 halt
        end
        return word;
    endfunction

    task automatic drive_inputs();
        if (reset_left > 0) begin
            reset = 1'b1;
            reset_left--;
        end else begin
            reset = 1'b0;
        end
        if (load_pending) begin // datapath takes the next word
            instruction_register = random_instruction();
            flags = condition_flags_t'(3'($random(seed)));
            load_pending = 1'b0;
        end
        accept = (($random(seed) & 32'd3) == 32'd0); // one in four
    endtask

    task automatic check_cycle();
        if (reset) begin
            check_control(control, '0);
            model_phase = fetch_address;
            model_step = '0;
        end else begin
            expected_control(model_phase, model_step, instruction_register, flags, accept,
                expected, expected_status);
            check_control(control, expected);
            case (model_phase)
                fetch_address: model_phase = fetch_load;
                fetch_load: begin
                    model_phase = execute;
                    load_pending = 1'b1;
                end
                execute: begin
                    if (expected_status.halt_request) begin
                        model_phase = halted;
                        halt_wait = 0;
                        instructions_done++;
                    end else if (expected_status.last_step) begin
                        model_phase = fetch_address;
                        model_step = '0;
                        instructions_done++;
                    end else if (instruction_register.trap.opcode != op_trap) begin
                        model_step = model_step + 2'd1; // input trap holds step 0
                    end
                end
                default: begin
                    halt_wait++;
                    if (halt_wait == 3) begin
                        reset_left = 16;
                    end
                end
            endcase
        end
    endtask

    initial begin
        seed = 32'hf6016f59;
        clock = 1'b0;
        reset = 1'b1;
        flags = '0;
        instruction_register = '0;
        accept = 1'b0;
        reset_left = 15; // already high for the first edge
        halt_wait = 0;
        load_pending = 1'b0;
        model_phase = fetch_address;
        model_step = '0;
        while (instructions_done < instruction_count) begin
            @(posedge clock);
            #2;
            drive_inputs();
            #36;
            check_cycle();
        end
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* rtl/lc3_control_unit.sv */
`timescale 1ns/1ps

module lc3_control_unit (
    input logic clock,
    input logic reset,
    input isa_pkg::condition_flags_t flags,
    input isa_pkg::instruction_t instruction_register,
    input logic accept,
    output control_pkg::control_word_t control
);
    import control_pkg::*;

    step_t step;
    control_word_t execute_control;
    step_status_t execute_status;

    instruction_sequencer i_instruction_sequencer (
        .clock(clock),
        .reset(reset),
        .execute_control(execute_control),
        .execute_status(execute_status),
        .step(step),
        .control(control)
    );

    execute_decoder i_execute_decoder (
        .instruction_register(instruction_register),
        .flags(flags),
        .accept(accept),
        .step(step),
        .execute_control(execute_control),
        .execute_status(execute_status)
    );

endmodule

/* rtl/instruction_sequencer.sv */
`timescale 1ns/1ps

module instruction_sequencer (
    input logic clock,
    input logic reset,
    input control_pkg::control_word_t execute_control,
    input control_pkg::step_status_t execute_status,
    output control_pkg::step_t step,
    output control_pkg::control_word_t control
);
    import control_pkg::*;

    phase_t phase;
    control_word_t fetch_address_control;
    control_word_t fetch_load_control;

    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= fetch_address;
            step <= '0;
        end else begin
            case (phase)
                fetch_address: phase <= fetch_load;
                fetch_load: phase <= execute;
                execute: begin
                    if (execute_status.halt_request) begin
                        phase <= halted;
                        step <= '0;
                    end else if (execute_status.last_step) begin
                        phase <= fetch_address;
                        step <= '0;
                    end else if (execute_control != '0) begin
                        step <= step + 2'd1;
                    end // idle step waits in place
                end
                halted: phase <= halted; // only reset leaves
                default: phase <= fetch_address;
            endcase
        end
    end

    always_comb begin
        fetch_address_control = '0;
        fetch_address_control.buses.program_counter = 1'b1; // pc onto address
        fetch_address_control.memory_read_enable = 1'b1;

        fetch_load_control = '0;
        fetch_load_control.buses.memory_data = 1'b1;
        fetch_load_control.program_counter_mux_select = pc_increment;
        fetch_load_control.loads.instruction_register = 1'b1;
        fetch_load_control.loads.program_counter = 1'b1;

        case (phase)
            fetch_address: control = fetch_address_control;
            fetch_load: control = fetch_load_control;
            execute: control = execute_control;
            default: control = '0;
        endcase
        if (reset) begin
            control = '0;
        end
    end

endmodule

/* rtl/execute_decoder.sv */
`timescale 1ns/1ps

module execute_decoder (
    input isa_pkg::instruction_t instruction_register,
    input isa_pkg::condition_flags_t flags,
    input logic accept,
    input control_pkg::step_t step,
    output control_pkg::control_word_t execute_control,
    output control_pkg::step_status_t execute_status
);
    import isa_pkg::*;
    import control_pkg::*;

    control_word_t operate_control;
    control_word_t memory_control;
    control_word_t flow_control;
    control_word_t trap_control;
    step_status_t operate_status;
    step_status_t memory_status;
    step_status_t flow_status;
    step_status_t trap_status;

    operate_decoder i_operate_decoder (
        .instruction_register(instruction_register),
        .step(step),
        .control(operate_control),
        .status(operate_status)
    );

    memory_access_decoder i_memory_access_decoder (
        .instruction_register(instruction_register),
        .step(step),
        .control(memory_control),
        .status(memory_status)
    );

    flow_decoder i_flow_decoder (
        .instruction_register(instruction_register),
        .flags(flags),
        .step(step),
        .control(flow_control),
        .status(flow_status)
    );

    trap_decoder i_trap_decoder (
        .instruction_register(instruction_register),
        .accept(accept),
        .control(trap_control),
        .status(trap_status)
    );

    always_comb begin
        case (instruction_register.operate.opcode)
            op_ld, op_st, op_ldr, op_str, op_ldi, op_sti: begin
                execute_control = memory_control;
                execute_status = memory_status;
            end
            op_br, op_jmp, op_jsr: begin
                execute_control = flow_control;
                execute_status = flow_status;
            end
            op_trap: begin
                execute_control = trap_control;
                execute_status = trap_status;
            end
            default: begin // add, and, not, lea, rti, reserved
                execute_control = operate_control;
                execute_status = operate_status;
            end
        endcase
    end

endmodule

/* rtl/trap_decoder.sv */
`timescale 1ns/1ps

module trap_decoder (
    input isa_pkg::instruction_t instruction_register,
    input logic accept,
    output control_pkg::control_word_t control,
    output control_pkg::step_status_t status
);
    import isa_pkg::*;
    import control_pkg::*;

    always_comb begin
        control = '0;
        status = '0;
        case (instruction_register.trap.vector)
            trap_display: begin
                control.loads.seven_segment_display_register = 1'b1;
                control.buses.register_file_out_a = 1'b1;
                control.register_file_out_a_address = instruction_register.trap.register;
                status.last_step = 1'b1;
            end
            trap_input: begin
                if (accept) begin // switches valid
                    control.loads.register_file = 1'b1;
                    control.buses.switch_input = 1'b1;
                    control.register_file_in_address = instruction_register.trap.register;
                    status.last_step = 1'b1;
                end
            end
            default: status.halt_request = 1'b1; // unknown vector halts
        endcase
    end

endmodule

/* rtl/flow_decoder.sv */
`timescale 1ns/1ps

module flow_decoder (
    input isa_pkg::instruction_t instruction_register,
    input isa_pkg::condition_flags_t flags,
    input control_pkg::step_t step,
    output control_pkg::control_word_t control,
    output control_pkg::step_status_t status
);
    import isa_pkg::*;
    import control_pkg::*;

    always_comb begin
        control = '0;
        status = '0;
        case (instruction_register.base.opcode)
            op_br: begin
                control.loads.program_counter = 1'b1;
                control.buses.program_counter = 1'b1;
                control.address_adder_mux_a_select = from_pc;
                control.address_adder_mux_b_select = sext9;
                // exact match of nzp against flags
                control.program_counter_mux_select =
                    (instruction_register.offset.dr_nzp == flags) ? pc_from_adder : pc_from_bus;
                status.last_step = 1'b1;
            end
            op_jmp: begin
                control.loads.program_counter = 1'b1;
                control.buses.register_file_out_a = 1'b1;
                control.register_file_out_a_address = instruction_register.base.base_r;
                control.program_counter_mux_select = pc_from_bus;
                status.last_step = 1'b1;
            end
            op_jsr: begin
                if (step == '0) begin // save return address
                    control.loads.register_file = 1'b1;
                    control.buses.program_counter = 1'b1;
                    control.register_file_in_address = link_register;
                end else begin
                    control.loads.program_counter = 1'b1;
                    if (instruction_register.jsr.long_flag) begin
                        control.address_adder_mux_a_select = from_pc;
                        control.address_adder_mux_b_select = sext11;
                        control.program_counter_mux_select = pc_from_adder;
                    end else begin
                        control.buses.register_file_out_a = 1'b1;
                        control.register_file_out_a_address = instruction_register.base.base_r;
                        control.program_counter_mux_select = pc_from_bus;
                    end
                    status.last_step = 1'b1;
                end
            end
            default: control = '0;
        endcase
    end

endmodule

/* rtl/memory_access_decoder.sv */
`timescale 1ns/1ps

module memory_access_decoder (
    input isa_pkg::instruction_t instruction_register,
    input control_pkg::step_t step,
    output control_pkg::control_word_t control,
    output control_pkg::step_status_t status
);
    import isa_pkg::*;
    import control_pkg::*;

    logic base_relative;
    logic indirect;
    logic is_store;
    control_word_t address_control;
    control_word_t writeback_control;

    always_comb begin
        base_relative = instruction_register.base.opcode inside {op_ldr, op_str};
        indirect = instruction_register.base.opcode inside {op_ldi, op_sti};
        is_store = instruction_register.base.opcode inside {op_st, op_str, op_sti};

        // effective address onto the bus
        address_control = '0;
        address_control.buses.memory_address = 1'b1;
        address_control.memory_address_register_mux_select = 1'b1;
        if (base_relative) begin
            address_control.register_file_out_a_address = instruction_register.base.base_r;
            address_control.address_adder_mux_a_select = from_register;
            address_control.address_adder_mux_b_select = sext6;
        end else begin
            address_control.address_adder_mux_a_select = from_pc;
            address_control.address_adder_mux_b_select = sext9;
        end

        writeback_control = '0;
        writeback_control.buses.memory_data = 1'b1;
        writeback_control.loads.register_file = 1'b1;
        writeback_control.loads.flag_register = 1'b1;
        writeback_control.register_file_in_address = instruction_register.base.dr_sr;

        control = '0;
        status = '0;
        if (is_store) begin
            case (step)
                2'd0: begin // source register into mdr
                    control.buses.register_file_out_a = 1'b1;
                    control.loads.memory_data_register = 1'b1;
                    control.register_file_out_a_address = instruction_register.base.dr_sr;
                end
                2'd1: begin
                    control = address_control;
                    control.memory_read_enable = indirect; // fetch pointer
                    control.memory_write_enable = !indirect;
                    status.last_step = !indirect;
                end
                default: begin // write through pointer
                    control.buses.memory_data = 1'b1;
                    control.memory_write_enable = 1'b1;
                    status.last_step = 1'b1;
                end
            endcase
        end else begin
            case (step)
                2'd0: begin
                    control = address_control;
                    control.memory_read_enable = 1'b1;
                end
                2'd1: begin
                    if (indirect) begin
                        control.buses.memory_data = 1'b1;
                        control.memory_read_enable = 1'b1;
                    end else begin
                        control = writeback_control;
                        status.last_step = 1'b1;
                    end
                end
                default: begin
                    control = writeback_control;
                    status.last_step = 1'b1;
                end
            endcase
        end
    end

endmodule

/* rtl/operate_decoder.sv */
`timescale 1ns/1ps

module operate_decoder (
    input isa_pkg::instruction_t instruction_register,
    input control_pkg::step_t step,
    output control_pkg::control_word_t control,
    output control_pkg::step_status_t status
);
    import isa_pkg::*;
    import control_pkg::*;

    always_comb begin
        control = '0;
        status = '0;
        status.last_step = 1'b1; // single step table
        if (step == '0) begin
            case (instruction_register.operate.opcode)
                op_add, op_and, op_not: begin
                    control.loads.register_file = 1'b1;
                    control.loads.flag_register = 1'b1;
                    control.buses.arithmetic_logic_unit = 1'b1;
                    control.register_file_in_address = instruction_register.operate.dr;
                    control.register_file_out_a_address = instruction_register.operate.sr1;
                    if (instruction_register.operate.opcode == op_not) begin
                        control.arithmetic_logic_unit_select = alu_not;
                    end else begin
                        if (!instruction_register.operate.imm_flag) begin
                            control.register_file_out_b_address = instruction_register.operate.sr2;
                            control.arithmetic_logic_mux_select = 1'b1; // second register
                        end
                        control.arithmetic_logic_unit_select =
                            (instruction_register.operate.opcode == op_and) ? alu_and : alu_add;
                    end
                end
                op_lea: begin
                    control.loads.register_file = 1'b1;
                    control.loads.flag_register = 1'b1;
                    control.buses.memory_address = 1'b1;
                    control.address_adder_mux_a_select = from_pc;
                    control.address_adder_mux_b_select = sext9;
                    control.memory_address_register_mux_select = 1'b1; // address from adder
                    control.register_file_in_address = instruction_register.offset.dr_nzp;
                end
                default: control = '0; // rti and reserved do nothing
            endcase
        end
    end

endmodule

/* rtl/control_pkg.sv */
package control_pkg;

    typedef struct packed {
        logic instruction_register;
        logic program_counter;
        logic register_file;
        logic memory_data_register;
        logic flag_register;
        logic seven_segment_display_register;
    } load_enables_t;

    typedef struct packed {
        logic memory_data;
        logic memory_address;
        logic arithmetic_logic_unit;
        logic program_counter;
        logic register_file_out_a;
        logic switch_input;
    } bus_enables_t;

    typedef struct packed {
        load_enables_t loads;
        bus_enables_t buses;
        isa_pkg::reg_addr_t register_file_in_address;
        isa_pkg::reg_addr_t register_file_out_a_address;
        isa_pkg::reg_addr_t register_file_out_b_address;
        logic memory_address_register_mux_select;
        logic [1:0] program_counter_mux_select;
        logic address_adder_mux_a_select;
        logic [1:0] address_adder_mux_b_select;
        logic arithmetic_logic_mux_select;
        logic [1:0] arithmetic_logic_unit_select;
        logic memory_read_enable;
        logic memory_write_enable;
    } control_word_t;

    localparam logic [1:0] pc_from_bus = 2'd0;
    localparam logic [1:0] pc_from_adder = 2'd1;
    localparam logic [1:0] pc_increment = 2'd2;

    localparam logic [1:0] sext6 = 2'd0;
    localparam logic [1:0] sext9 = 2'd1;
    localparam logic [1:0] sext11 = 2'd2;

    localparam logic from_register = 1'b0;
    localparam logic from_pc = 1'b1;

    localparam logic [1:0] alu_add = 2'd0;
    localparam logic [1:0] alu_not = 2'd1;
    localparam logic [1:0] alu_and = 2'd2;

    typedef enum logic [1:0] {
        fetch_address,
        fetch_load,
        execute,
        halted
    } phase_t;

    typedef logic [1:0] step_t;

    typedef struct packed {
        logic last_step;
        logic halt_request;
    } step_status_t;

endpackage

/* rtl/isa_pkg.sv */
package isa_pkg;

    typedef enum logic [3:0] {
        op_br = 4'h0, op_add, op_ld, op_st,
        op_jsr, op_and, op_ldr, op_str,
        op_rti, op_not, op_ldi, op_sti,
        op_jmp, op_reserved, op_lea, op_trap
    } opcode_t;

    typedef logic [2:0] reg_addr_t;

    localparam reg_addr_t link_register = 3'd7;

    localparam logic [7:0] trap_display = 8'd1; // write to seven segment display
    localparam logic [7:0] trap_input = 8'd2; // wait for switch input

    typedef struct packed {
        logic negative;
        logic zero;
        logic positive;
    } condition_flags_t;

    typedef struct packed {
        opcode_t opcode;
        reg_addr_t dr;
        reg_addr_t sr1;
        logic imm_flag;
        logic [1:0] unused;
        reg_addr_t sr2;
    } operate_view_t;

    typedef struct packed {
        opcode_t opcode;
        logic [2:0] dr_nzp; // dr, sr or branch condition
        logic [8:0] pc_offset9;
    } offset_view_t;

    typedef struct packed {
        opcode_t opcode;
        reg_addr_t dr_sr;
        reg_addr_t base_r;
        logic [5:0] offset6;
    } base_view_t;

    typedef struct packed {
        opcode_t opcode;
        logic long_flag;
        logic [10:0] pc_offset11;
    } jsr_view_t;

    typedef struct packed {
        opcode_t opcode;
        reg_addr_t register;
        logic unused;
        logic [7:0] vector;
    } trap_view_t;

    typedef union packed {
        operate_view_t operate;
        offset_view_t offset;
        base_view_t base;
        jsr_view_t jsr;
        trap_view_t trap;
    } instruction_t;

endpackage
